/* bench/rdma_header_model.svh */
// Reference model of the header beat, included inside the framer testbench module
`ifndef RDMA_HEADER_MODEL_SVH
`define RDMA_HEADER_MODEL_SVH

   // Network addressing used by the DUT instance and by the model
   localparam logic [7:0]  NET_SRC_MAC_LSB = 8'h37;
   localparam logic [31:0] NET_SRC_IP      = 32'hC0A8_0A05;
   localparam logic [31:0] NET_DST_IP      = 32'hC0A8_0A09;
   localparam logic [15:0] NET_SRC_PORT    = 16'd4791;
   localparam logic [15:0] NET_DST_PORT    = 16'd4792;

   // Writes a field in network order, most significant byte at the lowest offset
   function automatic stream_data_t put_bytes(input stream_data_t hdr, input int offset,
                                              input logic [63:0] value, input int nbytes);
      stream_data_t res;
      res = hdr;
      for (int k = 0; k < nbytes; k++) begin
         res[(offset + k)*8 +: 8] = value[(nbytes-1-k)*8 +: 8];
      end
      return res;
   endfunction

   // Ones' complement of the folded sum, checksum word taken as zero
   function automatic logic [15:0] ipv4_checksum(input logic [15:0] ip_len);
      logic [31:0] sum;
      sum = 32'(IP4_VER_DSF) + 32'(ip_len) + 32'(IP4_ID) + 32'(IP4_FLAGS);
      sum = sum + 32'(IP4_TTL_PROT);
      sum = sum + 32'(NET_SRC_IP[31:16]) + 32'(NET_SRC_IP[15:0]);
      sum = sum + 32'(NET_DST_IP[31:16]) + 32'(NET_DST_IP[15:0]);
      while (sum[31:16] != 16'h0000) begin
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);
      end
      return ~sum[15:0];
   endfunction

   // Expected header beat, byte 0 is the first byte on the wire
   function automatic stream_data_t expected_header(input rdma_fields_t f, input pkt_len_t plen);
      stream_data_t hdr;
      logic [15:0]  ip_len;
      logic [15:0]  udp_len;
      ip_len  = IP_HDR_LEN + UDP_HDR_LEN + RDMA_HDR_LEN + plen;
      udp_len = UDP_HDR_LEN + RDMA_HDR_LEN + plen;
      hdr = '0;
      // Ethernet
      hdr = put_bytes(hdr, 0, 64'(ETH_DST_MAC), 6);
      hdr = put_bytes(hdr, 6, 64'({ETH_SRC_MAC_HI, NET_SRC_MAC_LSB}), 6);
      hdr = put_bytes(hdr, 12, 64'(ETH_TYPE_IPV4), 2);
      // IPv4
      hdr = put_bytes(hdr, 14, 64'(IP4_VER_DSF), 2);
      hdr = put_bytes(hdr, 16, 64'(ip_len), 2);
      hdr = put_bytes(hdr, 18, 64'(IP4_ID), 2);
      hdr = put_bytes(hdr, 20, 64'(IP4_FLAGS), 2);
      hdr = put_bytes(hdr, 22, 64'(IP4_TTL_PROT), 2);
      hdr = put_bytes(hdr, 24, 64'(ipv4_checksum(ip_len)), 2);
      hdr = put_bytes(hdr, 26, 64'(NET_SRC_IP), 4);
      hdr = put_bytes(hdr, 30, 64'(NET_DST_IP), 4);
      // UDP, checksum bytes 40 and 41 stay zero
      hdr = put_bytes(hdr, 34, 64'(NET_SRC_PORT), 2);
      hdr = put_bytes(hdr, 36, 64'(NET_DST_PORT), 2);
      hdr = put_bytes(hdr, 38, 64'(udp_len), 2);
      // RDMA fields, bytes 51 to 63 reserved
      hdr = put_bytes(hdr, 42, 64'(f.target_addr), 8);
      hdr = put_bytes(hdr, 50, 64'(f.burst_len), 1);
      return hdr;
   endfunction

`endif

/* bench/rdma_xmit_tb.sv */
// Directed testbench for the RDMA transmit framer; compile with sim.f and run rdma_xmit_tb
`timescale 1ns/1ps
`default_nettype none

module rdma_xmit_tb import rdma_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   // Cycle budget of the whole sequence, the watchdog allows twice this
   localparam int TEST_CYCLES = 2000;

   logic         clk;
   logic         resetn;
   rdma_fields_t aw_fields;
   logic         aw_valid;
   logic         aw_ready;
   axi_w_beat_t  w_beat;
   logic         w_valid;
   logic         w_ready;
   logic         b_valid;
   logic [1:0]   b_resp;
   logic         b_ready;
   axis_beat_t   tx_beat;
   logic         tx_valid;
   logic         tx_ready;

   // Scoreboard
   axis_beat_t   exp_q [$];
   axis_beat_t   rx_q [$];
   int           rx_next = 0;
   int           checks = 0;
   int           errors = 0;
   int           resp_errors = 0;
   int           b_count = 0;
   int           bursts_sent = 0;
   logic         bp_enable;
   integer       seed = 40;
   int           rnd;

`include "rdma_header_model.svh"

   rdma_xmit #(
      .SRC_MAC_LSB(NET_SRC_MAC_LSB), .SRC_IP(NET_SRC_IP), .DST_IP(NET_DST_IP),
      .SRC_PORT(NET_SRC_PORT), .DST_PORT(NET_DST_PORT),
      .DATA_FIFO_DEPTH(16), .MAX_PACKET_COUNT(4)
   ) i_dut (
      .clk(clk), .resetn(resetn),
      .aw_fields(aw_fields), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .w_beat(w_beat), .w_valid(w_valid), .w_ready(w_ready),
      .b_valid(b_valid), .b_resp(b_resp), .b_ready(b_ready),
      .tx_beat(tx_beat), .tx_valid(tx_valid), .tx_ready(tx_ready)
   );

   // ========================================
   // Clock, TX ready, monitors, watchdog
   // ========================================
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Ready toggles pseudo-randomly only while back-pressure is on
   initial begin
      logic bp_now;
      tx_ready = 1'b1;
      forever begin
         @(posedge clk);
         // Enable sampled at the edge, ready driven after the hold delay
         bp_now = bp_enable;
         #10;
         if (bp_now) begin
            rnd = $random(seed);
            tx_ready = rnd[0];
         end else begin
            tx_ready = 1'b1;
         end
      end
   end

   // Sampled mid-cycle and taken on the next rising edge
   always @(negedge clk) begin
      if (resetn && tx_valid && tx_ready) begin
         rx_q.push_back(tx_beat);
      end
   end

   always @(negedge clk) begin
      if (resetn && b_valid && b_ready) begin
         b_count++;
         if (b_resp !== 2'b00) begin
            resp_errors++;
            $display("FAILED write_responses b_resp: expected 0, actual %0d", b_resp);
         end
      end
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("ERROR: watchdog expired, the tests did not finish in time");
      $display("Summary: %0d checks, %0d errors", checks, errors + resp_errors + 1);
      $display("TESTS FAILED");
      $finish;
   end

   // ========================================
   // Helpers
   // ========================================

   // Payload pattern depends on packet, beat and word
   function automatic stream_data_t beat_data(input int pkt_id, input int beat);
      stream_data_t d;
      for (int w = 0; w < STREAM_WBYTS / 4; w++) begin
         d[w*32 +: 32] = {8'(pkt_id), 8'(beat), 8'(w), 8'(pkt_id * 7 + beat * 3 + w)};
      end
      return d;
   endfunction

   function automatic stream_keep_t low_strobes(input int n);
      return stream_keep_t'((65'd1 << n) - 65'd1);
   endfunction

   task automatic expect_bit(input string name, input logic exp_v, input logic act_v);
      checks++;
      if (act_v !== exp_v) begin
         errors++;
         $display("FAILED %s: expected %b, actual %b", name, exp_v, act_v);
      end
   endtask

   // Queues the expected beats, then drives AW and the W beats
   task automatic send_packet(input axi_addr_t addr, input int nbeats, input int last_bytes,
                              input int pkt_id, input pkt_len_t exp_len);
      rdma_fields_t f;
      axis_beat_t   pb;
      logic         taken;
      f.target_addr = addr;
      f.burst_len   = burst_len_t'(nbeats - 1);
      pb.data = expected_header(f, exp_len);
      pb.keep = '1;
      pb.last = 1'b0;
      exp_q.push_back(pb);
      aw_fields = f;
      aw_valid  = 1'b1;
      taken     = 1'b0;
      while (!taken) begin
         taken = aw_ready;
         @(posedge clk);
         #10;
      end
      aw_valid = 1'b0;
      for (int b = 0; b < nbeats; b++) begin
         w_beat.data = beat_data(pkt_id, b);
         w_beat.last = (b == nbeats - 1);
         w_beat.strb = w_beat.last ? low_strobes(last_bytes) : '1;
         pb = '{data: w_beat.data, keep: w_beat.strb, last: w_beat.last};
         exp_q.push_back(pb);
         w_valid = 1'b1;
         taken   = 1'b0;
         while (!taken) begin
            taken = w_ready;
            @(posedge clk);
            #10;
         end
      end
      w_valid = 1'b0;
      bursts_sent++;
   endtask

   // Waits for the expected beats, compares them, then looks for strays
   task automatic check_beats(input string name);
      int         n;
      axis_beat_t eb;
      axis_beat_t ab;
      n = exp_q.size();
      while (rx_q.size() < rx_next + n) begin
         @(posedge clk);
         #10;
      end
      for (int i = 0; i < n; i++) begin
         eb = exp_q[i];
         ab = rx_q[rx_next + i];
         checks++;
         if (ab.data !== eb.data) begin
            errors++;
            $display("FAILED %s beat %0d data: expected %h, actual %h", name, i, eb.data, ab.data);
         end
         if (ab.keep !== eb.keep) begin
            errors++;
            $display("FAILED %s beat %0d keep: expected %h, actual %h", name, i, eb.keep, ab.keep);
         end
         if (ab.last !== eb.last) begin
            errors++;
            $display("FAILED %s beat %0d last: expected %b, actual %b", name, i, eb.last, ab.last);
         end
      end
      rx_next = rx_next + n;
      exp_q.delete();
      repeat (4) @(posedge clk);
      #10;
      if (rx_q.size() != rx_next) begin
         errors++;
         $display("ERROR: %s received %0d beats more than expected", name, rx_q.size() - rx_next);
         rx_next = rx_q.size();
      end
   endtask

   // ========================================
   // Tests
   // ========================================
   task automatic reset_state();
      int waited;
      waited = 0;
      repeat (4) @(posedge clk);
      #10;
      expect_bit("reset_state tx_valid in reset", 1'b0, tx_valid);
      expect_bit("reset_state b_valid in reset", 1'b0, b_valid);
      expect_bit("reset_state aw_ready in reset", 1'b0, aw_ready);
      expect_bit("reset_state w_ready in reset", 1'b0, w_ready);
      resetn = 1'b1;
      while (!(aw_ready && w_ready) && waited < 4) begin
         @(posedge clk);
         #10;
         waited++;
      end
      expect_bit("reset_state aw_ready", 1'b1, aw_ready);
      expect_bit("reset_state w_ready", 1'b1, w_ready);
      expect_bit("reset_state tx_valid", 1'b0, tx_valid);
      expect_bit("reset_state b_valid", 1'b0, b_valid);
   endtask

   task automatic single_full_packet();
      send_packet(64'h0000_1000_0000_0040, 3, 64, 1, 16'd192);
      check_beats("single_full_packet");
   endtask

   task automatic partial_last_beat();
      send_packet(64'h0000_2000_0000_1000, 2, 5, 2, 16'd69);
      check_beats("partial_last_beat");
   endtask

   task automatic back_to_back_bursts();
      send_packet(64'h0000_3000_0000_0000, 2, 64, 3, 16'd128);
      send_packet(64'h0000_3000_0000_8000, 1, 12, 4, 16'd12);
      send_packet(64'hFFFF_0000_1234_5678, 4, 33, 5, 16'd225);
      check_beats("back_to_back_bursts");
   endtask

   task automatic tx_backpressure();
      bp_enable = 1'b1;
      send_packet(64'h0000_4000_0000_0100, 3, 64, 6, 16'd192);
      send_packet(64'h0000_4000_0000_0200, 2, 40, 7, 16'd104);
      check_beats("tx_backpressure");
      bp_enable = 1'b0;
   endtask

   task automatic write_responses();
      int waited;
      waited = 0;
      while (b_count != bursts_sent && waited < 10) begin
         @(posedge clk);
         #10;
         waited++;
      end
      checks++;
      if (b_count != bursts_sent) begin
         errors++;
         $display("FAILED write_responses count: expected %0d, actual %0d", bursts_sent, b_count);
      end
   endtask

   initial begin
      resetn    = 1'b0;
      aw_fields = '0;
      aw_valid  = 1'b0;
      w_beat    = '0;
      w_valid   = 1'b0;
      b_ready   = 1'b1;
      bp_enable = 1'b0;
      reset_state();
      single_full_packet();
      partial_last_beat();
      back_to_back_bursts();
      tx_backpressure();
      write_responses();
      $display("Summary: %0d checks, %0d errors", checks, errors + resp_errors);
      if (errors + resp_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the framer testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

verilator --binary --timing --assert -f sim.f --top-module rdma_xmit_tb \
   -Mdir obj_dir -o rdma_xmit_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/rdma_xmit_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1

/* sim.f */
+incdir+bench
source/rdma_pkg.sv
source/sync_fifo.sv
source/write_ingest.sv
source/rdma_header_build.sv
source/tx_sequencer.sv
source/rdma_xmit.sv
bench/rdma_xmit_tb.sv

/* source/rdma_header_build.sv */
// Combinational builder of the 64-byte Ethernet/IPv4/UDP/RDMA header beat in wire byte order
`timescale 1ns/1ps
`default_nettype none

module rdma_header_build import rdma_pkg::*; #(
   parameter logic [7:0]  SRC_MAC_LSB = 8'd2,
   parameter logic [31:0] SRC_IP      = 32'h0A01_0102,
   parameter logic [31:0] DST_IP      = 32'h0A01_01FF,
   parameter logic [15:0] SRC_PORT    = 16'd1000,
   parameter logic [15:0] DST_PORT    = 16'd32002
) (
   input  wire rdma_fields_t fields,
   input  wire pkt_len_t     pkt_len,
   output stream_data_t      header
);

   pkt_len_t     ip4_length;
   pkt_len_t     udp_length;
   logic [31:0]  cs_sum;
   logic [16:0]  cs_fold;
   logic [15:0]  cs_end;
   logic [15:0]  ip4_checksum;
   stream_data_t hdr_be;

   // ========================================
   // Lengths
   // ========================================
   assign ip4_length = IP_HDR_LEN + UDP_HDR_LEN + RDMA_HDR_LEN + pkt_len;
   assign udp_length = UDP_HDR_LEN + RDMA_HDR_LEN + pkt_len;

   // ========================================
   // IPv4 checksum
   // ========================================

   // Nine header words, checksum field counted as zero
   assign cs_sum = 32'(IP4_VER_DSF) + 32'(ip4_length) + 32'(IP4_ID) + 32'(IP4_FLAGS)
                 + 32'(IP4_TTL_PROT)
                 + 32'(SRC_IP[31:16]) + 32'(SRC_IP[15:0])
                 + 32'(DST_IP[31:16]) + 32'(DST_IP[15:0]);

   // Fold the upper half in, then the end-around carry
   assign cs_fold      = 17'(cs_sum[15:0]) + 17'(cs_sum[31:16]);
   assign cs_end       = cs_fold[15:0] + 16'(cs_fold[16]);
   assign ip4_checksum = ~cs_end;

   // ========================================
   // Header assembly
   // ========================================

   // First field at the top, 42 bytes of network headers then 22 of RDMA fields
   assign hdr_be = {
      // Ethernet, 14 bytes
      ETH_DST_MAC,
      ETH_SRC_MAC_HI, SRC_MAC_LSB,
      ETH_TYPE_IPV4,
      // IPv4, 20 bytes
      IP4_VER_DSF, ip4_length, IP4_ID, IP4_FLAGS, IP4_TTL_PROT, ip4_checksum,
      SRC_IP,
      DST_IP,
      // UDP, 8 bytes with no checksum
      SRC_PORT, DST_PORT, udp_length, 16'h0000,
      // RDMA fields and reserved zeros
      fields.target_addr,
      fields.burst_len,
      {(RDMA_RSVD_BYTES * 8){1'b0}}
   };

   // MAC sends byte 0 first, so the first field moves to the bottom byte
   always_comb begin
      for (int i = 0; i < STREAM_WBYTS; i++) begin
         header[i*8 +: 8] = hdr_be[(STREAM_WBYTS-1-i)*8 +: 8];
      end
   end

endmodule

`default_nettype wire

/* source/rdma_pkg.sv */
// Common widths, beat structs, header constants and FSM states, imported by every framer module
`default_nettype none

package rdma_pkg;

   // ========================================
   // Stream geometry
   // ========================================

   // Bus width in bytes, and in bits
   localparam int STREAM_WBYTS = 64;
   localparam int STREAM_WBITS = STREAM_WBYTS * 8;

   typedef logic [STREAM_WBITS-1:0] stream_data_t;
   typedef logic [STREAM_WBYTS-1:0] stream_keep_t;

   // AXI write address and AWLEN
   typedef logic [63:0] axi_addr_t;
   typedef logic [7:0]  burst_len_t;

   // Payload byte count of one packet
   typedef logic [15:0] pkt_len_t;

   // Bytes in one beat, 0 to 64
   typedef logic [6:0]  beat_bytes_t;

   // Write transactions received or answered
   typedef logic [15:0] xact_count_t;

   // ========================================
   // Header constants
   // ========================================

   // Header lengths in bytes
   localparam pkt_len_t IP_HDR_LEN   = 16'd20;
   localparam pkt_len_t UDP_HDR_LEN  = 16'd8;
   localparam pkt_len_t RDMA_HDR_LEN = 16'd22;

   // Zero bytes that pad the RDMA fields out to a full beat
   localparam int RDMA_RSVD_BYTES = 13;

   // Ethernet fields
   localparam logic [47:0] ETH_DST_MAC    = 48'hFFFF_FFFF_FFFF;
   localparam logic [39:0] ETH_SRC_MAC_HI = 40'hC4_00AD_0000;
   localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;

   // Fixed IPv4 words
   localparam logic [15:0] IP4_VER_DSF  = 16'h4500;
   localparam logic [15:0] IP4_ID       = 16'hDEAD;
   localparam logic [15:0] IP4_FLAGS    = 16'h4000;
   localparam logic [15:0] IP4_TTL_PROT = 16'h4011;

   // ========================================
   // Beat and field structs
   // ========================================

   // One AW entry, what the address queue stores
   typedef struct packed {
      axi_addr_t  target_addr;
      burst_len_t burst_len;
   } rdma_fields_t;

   // One W channel beat
   typedef struct packed {
      stream_data_t data;
      stream_keep_t strb;
      logic         last;
   } axi_w_beat_t;

   // One stream beat, payload queue head and TX output
   typedef struct packed {
      stream_data_t data;
      stream_keep_t keep;
      logic         last;
   } axis_beat_t;

   // Transmit FSM states
   typedef enum logic [1:0] {
      TX_INIT,
      TX_HEADER,
      TX_PAYLOAD
   } tx_state_t;

endpackage

`default_nettype wire

/* source/rdma_xmit.sv */
// Top level of the RDMA transmit framer, AXI4 write slave in and sparse header-plus-payload out
`timescale 1ns/1ps
`default_nettype none

module rdma_xmit import rdma_pkg::*; #(
   parameter logic [7:0]  SRC_MAC_LSB      = 8'd2,
   parameter logic [31:0] SRC_IP           = 32'h0A01_0102,
   parameter logic [31:0] DST_IP           = 32'h0A01_01FF,
   parameter logic [15:0] SRC_PORT         = 16'd1000,
   parameter logic [15:0] DST_PORT         = 16'd32002,
   // Payload beats, and packets in flight
   parameter int          DATA_FIFO_DEPTH  = 256,
   parameter int          MAX_PACKET_COUNT = 16
) (
   input  wire               clk,
   input  wire               resetn,
   // AW channel
   input  wire rdma_fields_t aw_fields,
   input  wire               aw_valid,
   output logic              aw_ready,
   // W channel
   input  wire axi_w_beat_t  w_beat,
   input  wire               w_valid,
   output logic              w_ready,
   // B channel
   output logic              b_valid,
   output logic [1:0]        b_resp,
   input  wire               b_ready,
   // Outgoing sparse stream
   output axis_beat_t        tx_beat,
   output logic              tx_valid,
   input  wire               tx_ready
);

   // Queue heads between ingest and sequencer
   pkt_len_t     len_head;
   logic         len_valid;
   logic         len_pop;
   rdma_fields_t addr_head;
   logic         addr_valid;
   logic         addr_pop;
   axis_beat_t   data_head;
   logic         data_valid;
   logic         data_pop;

   // Header path
   rdma_fields_t hdr_fields;
   stream_data_t header;

   write_ingest #(
      .DATA_FIFO_DEPTH(DATA_FIFO_DEPTH), .MAX_PACKET_COUNT(MAX_PACKET_COUNT)
   ) i_ingest (
      .clk(clk), .resetn(resetn),
      .aw_fields(aw_fields), .aw_valid(aw_valid), .aw_ready(aw_ready),
      .w_beat(w_beat), .w_valid(w_valid), .w_ready(w_ready),
      .b_valid(b_valid), .b_resp(b_resp), .b_ready(b_ready),
      .len_head(len_head), .len_valid(len_valid), .len_pop(len_pop),
      .addr_head(addr_head), .addr_valid(addr_valid), .addr_pop(addr_pop),
      .data_head(data_head), .data_valid(data_valid), .data_pop(data_pop)
   );

   tx_sequencer i_sequencer (
      .clk(clk), .resetn(resetn),
      .len_head(len_head), .len_valid(len_valid), .len_pop(len_pop),
      .addr_head(addr_head), .addr_valid(addr_valid), .addr_pop(addr_pop),
      .data_head(data_head), .data_valid(data_valid), .data_pop(data_pop),
      .header(header), .hdr_fields(hdr_fields),
      .tx_beat(tx_beat), .tx_valid(tx_valid), .tx_ready(tx_ready)
   );

   // Length comes straight from the queue head, which holds until the header is taken
   rdma_header_build #(
      .SRC_MAC_LSB(SRC_MAC_LSB), .SRC_IP(SRC_IP), .DST_IP(DST_IP),
      .SRC_PORT(SRC_PORT), .DST_PORT(DST_PORT)
   ) i_header (
      .fields(hdr_fields), .pkt_len(len_head), .header(header)
   );

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
// Show-ahead synchronous FIFO; the head word is presented whenever the FIFO holds data
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  wire              clk,
   input  wire              resetn,
   input  wire [WIDTH-1:0]  wr_data,
   input  wire              wr_en,
   output logic             full,
   output logic [WIDTH-1:0] rd_data,
   output logic             rd_valid,
   input  wire              rd_en
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             push;
   logic             pop;

   // Pointer step with wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push       = wr_en && !full;
   assign pop        = rd_en && rd_valid;
   assign count_next = count + CNT_W'(push) - CNT_W'(pop);

   // Full is registered and held high in reset, so nothing lands before the queue is clear
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b1;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         count <= count_next;
         full  <= (count_next == CNT_W'(DEPTH));
      end
   end

   // Storage array
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= wr_data;
   end

   // Head of queue
   assign rd_data  = mem[rd_ptr];
   assign rd_valid = (count != '0);

   // Callers must respect full and valid
   a_no_overflow : assert property (@(posedge clk) disable iff (!resetn) wr_en |-> !full);
   a_no_underflow : assert property (@(posedge clk) disable iff (!resetn) rd_en |-> rd_valid);

endmodule

`default_nettype wire

/* source/tx_sequencer.sv */
// Transmit FSM; emits one header beat per queued packet and then drains its payload onto TX
`timescale 1ns/1ps
`default_nettype none

module tx_sequencer import rdma_pkg::*; (
   input  wire               clk,
   input  wire               resetn,
   input  wire pkt_len_t     len_head,
   input  wire               len_valid,
   output logic              len_pop,
   input  wire rdma_fields_t addr_head,
   input  wire               addr_valid,
   output logic              addr_pop,
   input  wire axis_beat_t   data_head,
   input  wire               data_valid,
   output logic              data_pop,
   input  wire stream_data_t header,
   output rdma_fields_t      hdr_fields,
   output axis_beat_t        tx_beat,
   output logic              tx_valid,
   input  wire               tx_ready
);

   tx_state_t    state;
   rdma_fields_t held_fields;
   logic         held_valid;
   logic         addr_ready;
   logic         hdr_fire;

   // ========================================
   // Address hold
   // ========================================

   // Take the next address early, while the payload may still be arriving
   assign addr_pop   = (state == TX_HEADER) && addr_valid && !held_valid;
   assign addr_ready = held_valid || addr_pop;

   // Straight from the queue head on the cycle it arrives
   assign hdr_fields = held_valid ? held_fields : addr_head;

   always_ff @(posedge clk) begin
      if (addr_pop) held_fields <= addr_head;
   end

   // ========================================
   // Handshakes
   // ========================================

   // Header beat is offered once both a length and an address are in hand
   assign hdr_fire = (state == TX_HEADER) && len_valid && addr_ready && tx_ready;
   assign len_pop  = hdr_fire;
   assign data_pop = (state == TX_PAYLOAD) && data_valid && tx_ready;

   always_comb begin
      tx_beat  = '0;
      tx_valid = 1'b0;
      case (state)
         TX_HEADER: begin
            tx_beat  = '{data: header, keep: '1, last: 1'b0};
            tx_valid = len_valid && addr_ready;
         end
         TX_PAYLOAD: begin
            tx_beat  = data_head;
            tx_valid = data_valid;
         end
         default: begin
            tx_beat  = '0;
            tx_valid = 1'b0;
         end
      endcase
   end

   // ========================================
   // State machine
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state      <= TX_INIT;
         held_valid <= 1'b0;
      end else begin
         case (state)
            // One settling cycle after reset
            TX_INIT: state <= TX_HEADER;
            TX_HEADER: begin
               if (hdr_fire) begin
                  state      <= TX_PAYLOAD;
                  held_valid <= 1'b0;
               end else if (addr_pop) begin
                  held_valid <= 1'b1;
               end
            end
            // Back to headers after the last payload beat
            TX_PAYLOAD: if (data_pop && data_head.last) state <= TX_HEADER;
            default: state <= TX_INIT;
         endcase
      end
   end

   // Stream rule, an offered beat holds until taken
   a_tx_stable : assert property (@(posedge clk) disable iff (!resetn)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat));

endmodule

`default_nettype wire

/* source/write_ingest.sv */
// AXI write slave; queues address, payload and measured length per burst, and answers on B
`timescale 1ns/1ps
`default_nettype none

module write_ingest import rdma_pkg::*; #(
   parameter int DATA_FIFO_DEPTH  = 256,
   parameter int MAX_PACKET_COUNT = 16
) (
   input  wire               clk,
   input  wire               resetn,
   input  wire rdma_fields_t aw_fields,
   input  wire               aw_valid,
   output logic              aw_ready,
   input  wire axi_w_beat_t  w_beat,
   input  wire               w_valid,
   output logic              w_ready,
   output logic              b_valid,
   output logic [1:0]        b_resp,
   input  wire               b_ready,
   output pkt_len_t          len_head,
   output logic              len_valid,
   input  wire               len_pop,
   output rdma_fields_t      addr_head,
   output logic              addr_valid,
   input  wire               addr_pop,
   output axis_beat_t        data_head,
   output logic              data_valid,
   input  wire               data_pop
);

   logic        addr_full;
   logic        data_full;
   logic        len_full;
   logic        w_fire;
   beat_bytes_t beat_bytes;
   pkt_len_t    byte_count;
   pkt_len_t    len_total;
   axis_beat_t  w_as_axis;
   xact_count_t xact_rcvd;
   xact_count_t xact_resp;

   assign aw_ready = !addr_full;
   assign w_ready  = !data_full && !len_full;
   assign w_fire   = w_valid && w_ready;

   // ========================================
   // Byte counting
   // ========================================

   // Set strobes in this beat
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < STREAM_WBYTS; i++) begin
         beat_bytes = beat_bytes + beat_bytes_t'(w_beat.strb[i]);
      end
   end

   // Packet length including the current beat
   assign len_total = byte_count + pkt_len_t'(beat_bytes);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         byte_count <= '0;
      end else if (w_fire) begin
         byte_count <= w_beat.last ? '0 : len_total;
      end
   end

   // W beat recast as a stream beat, strobes become keep
   assign w_as_axis = '{data: w_beat.data, keep: w_beat.strb, last: w_beat.last};

   // ========================================
   // Queues
   // ========================================
   sync_fifo #(.WIDTH($bits(axis_beat_t)), .DEPTH(DATA_FIFO_DEPTH)) payload_fifo (
      .clk(clk), .resetn(resetn),
      .wr_data(w_as_axis), .wr_en(w_fire), .full(data_full),
      .rd_data(data_head), .rd_valid(data_valid), .rd_en(data_pop)
   );

   sync_fifo #(.WIDTH($bits(pkt_len_t)), .DEPTH(MAX_PACKET_COUNT)) length_fifo (
      .clk(clk), .resetn(resetn),
      .wr_data(len_total), .wr_en(w_fire && w_beat.last), .full(len_full),
      .rd_data(len_head), .rd_valid(len_valid), .rd_en(len_pop)
   );

   sync_fifo #(.WIDTH($bits(rdma_fields_t)), .DEPTH(MAX_PACKET_COUNT)) address_fifo (
      .clk(clk), .resetn(resetn),
      .wr_data(aw_fields), .wr_en(aw_valid && aw_ready), .full(addr_full),
      .rd_data(addr_head), .rd_valid(addr_valid), .rd_en(addr_pop)
   );

   // ========================================
   // Write response
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         xact_rcvd <= '0;
         xact_resp <= '0;
      end else begin
         if (w_fire && w_beat.last) xact_rcvd <= xact_rcvd + 1'b1;
         if (b_valid && b_ready)    xact_resp <= xact_resp + 1'b1;
      end
   end

   // Pending while some burst is still unanswered, always OKAY
   assign b_valid = (xact_rcvd != xact_resp);
   assign b_resp  = 2'b00;

   // Payload must be byte packed, only the last beat may be partial
   a_packed_beats : assert property (@(posedge clk) disable iff (!resetn)
      w_fire && !w_beat.last |-> &w_beat.strb);

endmodule

`default_nettype wire
